/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsu_pkg.sv
      - hw/data_sram.sv
      - hw/m1_stage.sv
      - hw/mem_stage.sv
      - hw/wb_stage.sv
      - hw/lsu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/lsu_tb.sv

/* bench/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int NUM_OPS = 400;
    localparam int WATCHDOG_CYCLES = NUM_OPS * (4 + `SRAM_MAX_WAIT) * 4;
    localparam mem_op_t LOAD_MASK = (mem_op_t'(1) << `MOP_LW)  | (mem_op_t'(1) << `MOP_LB)  |
                                    (mem_op_t'(1) << `MOP_LBU) | (mem_op_t'(1) << `MOP_LH)  |
                                    (mem_op_t'(1) << `MOP_LHU) | (mem_op_t'(1) << `MOP_LWL) |
                                    (mem_op_t'(1) << `MOP_LWR);

    logic       clk = 1'b0;
    logic       reset;
    logic       in_valid;
    ex_to_m1_t  in_bus;
    logic       in_allowin;
    logic       commit_valid;
    wb_commit_t commit;
    logic       commit_ready;
    ms_fwd_t    ms_fwd;

    // separate streams for stimulus and back-pressure
    int seed = 26783;
    int ready_seed = 26783;

    // word-indexed reference memory image
    logic [31:0] img [0:`LSU_DEPTH-1];
    // expected commits and bypass views with the oldest first
    wb_commit_t  exp_q[$];
    ms_fwd_t     fwd_q[$];
    int          n_commit = 0;

    lsu_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_bus       (in_bus),
        .in_allowin   (in_allowin),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .ms_fwd       (ms_fwd)
    );

    always #10 clk = ~clk;

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic string commit_text(input wb_commit_t c);
        return $sformatf("gr_we=%0b dest=%0d data=%h ex=%0b pc=%h",
                         c.gr_we, c.dest, c.data, c.ex, c.pc);
    endfunction

    function automatic string fwd_text(input ms_fwd_t f);
        return $sformatf("dest=%0d result=%h load_op=%0b", f.dest, f.result, f.load_op);
    endfunction

    task automatic stop_with_message(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_commit(input string name, input wb_commit_t exp, input wb_commit_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %s, actual %s",
                     name, commit_text(exp), commit_text(act));
            $display("** FAIL **");
            $fatal(1, "commit mismatch");
        end
    endtask

    task automatic check_fwd(input string name, input ms_fwd_t exp, input ms_fwd_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %s, actual %s",
                     name, fwd_text(exp), fwd_text(act));
            $display("** FAIL **");
            $fatal(1, "bypass mismatch");
        end
    endtask

    // expected commit from the load rules and the store effect on the image
    task automatic apply_to_model(input ex_to_m1_t b);
        wb_commit_t          c;
        ms_fwd_t             f;
        logic [31:0]         w;
        logic [`LSU_AW-3:0]  widx;
        logic [7:0]          bt;
        logic [15:0]         hf;
        int                  o;
        widx = b.result[`LSU_AW-1:2];
        o = b.result[1:0];
        w = img[widx];
        bt = w[o*8 +: 8];
        hf = w[(o / 2)*16 +: 16];
        c.gr_we = b.gr_we && !b.ex;
        c.dest = b.dest;
        c.data = b.result;
        c.ex = b.ex;
        c.pc = b.pc;
        if (!b.ex) begin
            if (b.op[`MOP_LW]) begin
                c.data = w;
            end else if (b.op[`MOP_LB]) begin
                c.data = 32'(signed'(bt));
            end else if (b.op[`MOP_LBU]) begin
                c.data = 32'(bt);
            end else if (b.op[`MOP_LH]) begin
                c.data = 32'(signed'(hf));
            end else if (b.op[`MOP_LHU]) begin
                c.data = 32'(hf);
            end else if (b.op[`MOP_LWL]) begin
                // top o+1 result bytes come from the low memory bytes
                for (int i = 0; i < 4; i++) begin
                    if (i >= 3 - o) begin
                        c.data[i*8 +: 8] = w[(i - 3 + o)*8 +: 8];
                    end else begin
                        c.data[i*8 +: 8] = b.rt_value[i*8 +: 8];
                    end
                end
            end else if (b.op[`MOP_LWR]) begin
                // bottom 4-o result bytes from memory starting at the offset
                for (int i = 0; i < 4; i++) begin
                    if (i <= 3 - o) begin
                        c.data[i*8 +: 8] = w[(i + o)*8 +: 8];
                    end else begin
                        c.data[i*8 +: 8] = b.rt_value[i*8 +: 8];
                    end
                end
            end else if (b.op[`MOP_SW]) begin
                img[widx] = b.rt_value;
            end else if (b.op[`MOP_SH]) begin
                img[widx][(o / 2)*16 +: 16] = b.rt_value[15:0];
            end else if (b.op[`MOP_SB]) begin
                img[widx][o*8 +: 8] = b.rt_value[7:0];
            end
        end
        f.dest = b.dest;
        f.result = b.result;
        f.load_op = |(b.op & LOAD_MASK);
        exp_q.push_back(c);
        fwd_q.push_back(f);
    endtask

    // one op with size-aligned address into a spread of 16 words
    task automatic build_random_op(input int n, output ex_to_m1_t b);
        int                 k;
        logic [1:0]         off;
        logic [`LSU_AW-3:0] widx;
        k = rand_below(11);
        off = 2'(rand_below(4));
        widx = (`LSU_AW-2)'(rand_below(16) * 17);
        if (k == `MOP_LW || k == `MOP_SW) begin
            off = 2'd0;
        end else if (k == `MOP_LH || k == `MOP_LHU || k == `MOP_SH) begin
            off[0] = 1'b0;
        end
        b.op = (k < `MOP_W) ? (mem_op_t'(1) << k) : '0;
        b.ex = (rand_below(8) == 0);
        b.gr_we = (k == `MOP_SW || k == `MOP_SB || k == `MOP_SH) ? 1'b0 : 1'(rand_below(2));
        b.dest = 5'(rand_below(32));
        b.result = (k < `MOP_W) ? {{(32-`LSU_AW){1'b0}}, widx, off} : $random(seed);
        b.rt_value = $random(seed);
        b.pc = 32'h0040_0000 + 32'(n * 4);
    endtask

    // called on a rising edge and returns on the edge that took the op
    task automatic send_op(input ex_to_m1_t b);
        logic done;
        in_valid <= 1'b1;
        in_bus <= b;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_allowin;
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    // random back-pressure with ready about three cycles in four
    always @(posedge clk) begin
        if (reset) begin
            commit_ready <= 1'b0;
        end else begin
            commit_ready <= ({$random(ready_seed)} % 4) != 0;
        end
    end

    // all handshakes settled by the falling edge
    always @(negedge clk) begin
        int idx;
        if (!reset) begin
            // bypass first against the queue before this cycle's pop
            if (ms_fwd.dest != 5'd0) begin
                idx = commit_valid ? 1 : 0;
                if (exp_q.size() <= idx) begin
                    stop_with_message($sformatf("bypass shows dest %0d with no op in mem_stage",
                                                ms_fwd.dest));
                end
                check_fwd($sformatf("bypass before commit %0d", n_commit), fwd_q[idx], ms_fwd);
            end
            if (commit_valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_message("commit appeared with no operation outstanding");
                end
                check_commit($sformatf("commit %0d", n_commit), exp_q[0], commit);
                if (commit_ready) begin
                    exp_q.pop_front();
                    fwd_q.pop_front();
                    n_commit++;
                end
            end
            if (in_valid && in_allowin) begin
                apply_to_model(in_bus);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d commits outstanding",
                 WATCHDOG_CYCLES, exp_q.size());
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        ex_to_m1_t b;
        reset = 1'b1;
        in_valid = 1'b0;
        in_bus = '0;
        commit_ready = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // clear every word with full-strobe stores
        for (int i = 0; i < `LSU_DEPTH; i++) begin
            b = '0;
            b.op = mem_op_t'(1) << `MOP_SW;
            b.result = 32'(i * 4);
            b.pc = 32'h0000_1000 + 32'(i * 4);
            send_op(b);
        end
        for (int n = 0; n < NUM_OPS; n++) begin
            build_random_op(n, b);
            send_op(b);
            repeat (rand_below(3)) @(posedge clk);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // idle tail where any extra commit trips the monitor
        repeat (8) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

/* hw/data_sram.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module data_sram import lsu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  mem_req_t    mem_req,
    output logic [31:0] rdata,
    output logic        busy
);

    localparam int WAIT_W = $clog2(`SRAM_MAX_WAIT + 1);

    logic [31:0]         mem [0:`LSU_DEPTH-1];
    logic [`LSU_AW-3:0]  widx;
    logic [7:0]          lfsr;
    logic [WAIT_W-1:0]   wait_cnt;
    logic                rd_req;

    // word index, byte offset dropped
    assign widx   = mem_req.addr[`LSU_AW-1:2];
    assign rd_req = mem_req.en && !mem_req.we;

    // x^8+x^6+x^5+x^4+1, free running
    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= 8'hb5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // byte-strobe write, finishes on its own edge
    always_ff @(posedge clk) begin
        if (mem_req.en && mem_req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (mem_req.wstrb[i]) begin
                    mem[widx][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    // read word held until the next read
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rdata <= mem[widx];
        end
    end

    // 0..max busy cycles after each read
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (rd_req) begin
            wait_cnt <= WAIT_W'(lfsr % (`SRAM_MAX_WAIT + 1));
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign busy = (wait_cnt != '0);

endmodule

/* hw/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// byte address width, 1 KiB data memory
`define LSU_AW 10
// words in the data memory
`define LSU_DEPTH 256

// one-hot memory op bit positions
`define MOP_LW  0
`define MOP_LB  1
`define MOP_LBU 2
`define MOP_LH  3
`define MOP_LHU 4
`define MOP_LWL 5
`define MOP_LWR 6
`define MOP_SW  7
`define MOP_SB  8
`define MOP_SH  9
`define MOP_W   10

// longest busy stretch after a read
`define SRAM_MAX_WAIT 3

`endif

/* hw/lsu_pkg.sv */
`include "lsu_consts.svh"

package lsu_pkg;

    // one-hot, all zeros is a plain alu op
    typedef logic [`MOP_W-1:0] mem_op_t;

    // operation handed over by execute
    typedef struct packed {
        mem_op_t     op;
        logic        ex;
        logic        gr_we;
        logic [4:0]  dest;
        // address for memory ops, alu value otherwise
        logic [31:0] result;
        // store data or lwl/lwr merge source
        logic [31:0] rt_value;
        logic [31:0] pc;
    } ex_to_m1_t;

    typedef struct packed {
        mem_op_t     op;
        logic        ex;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] result;
        logic [31:0] rt_value;
        logic [31:0] pc;
        // no read pending, mem_stage need not wait
        logic        store_flow;
    } m1_to_ms_t;

    typedef struct packed {
        mem_op_t     op;
        logic        ex;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] result;
        logic [31:0] rt_value;
        logic [31:0] pc;
        logic [31:0] rdata;
    } ms_to_ws_t;

    // request into the data memory
    typedef struct packed {
        logic              en;
        logic              we;
        logic [3:0]        wstrb;
        logic [`LSU_AW-1:0] addr;
        logic [31:0]       wdata;
    } mem_req_t;

    // bypass to decode
    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] result;
        logic        load_op;
    } ms_fwd_t;

    // one register-file commit
    typedef struct packed {
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] data;
        logic        ex;
        logic [31:0] pc;
    } wb_commit_t;

    // one data word, by word, byte lane or half lane
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } data_word_u;

endpackage

/* hw/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // from execute
    input  logic       in_valid,
    input  ex_to_m1_t  in_bus,
    output logic       in_allowin,
    // commit side
    output logic       commit_valid,
    output wb_commit_t commit,
    input  logic       commit_ready,
    // bypass to decode
    output ms_fwd_t    ms_fwd
);

    logic        m1_to_ms_valid;
    m1_to_ms_t   m1_to_ms_bus;
    logic        ms_allowin;
    logic        ms_to_ws_valid;
    ms_to_ws_t   ms_to_ws_bus;
    logic        ws_allowin;
    mem_req_t    mem_req;
    logic [31:0] rdata;
    logic        busy;

    // request stage
    m1_stage i_m1_stage (
        .clk            (clk),
        .reset          (reset),
        .es_valid       (in_valid),
        .es_bus         (in_bus),
        .m1_allowin     (in_allowin),
        .ms_allowin     (ms_allowin),
        .m1_to_ms_valid (m1_to_ms_valid),
        .m1_to_ms_bus   (m1_to_ms_bus),
        .mem_req        (mem_req)
    );

    // waits out memory busy
    mem_stage i_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .m1_to_ms_valid (m1_to_ms_valid),
        .m1_to_ms_bus   (m1_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .rdata          (rdata),
        .busy           (busy),
        .ms_fwd         (ms_fwd)
    );

    // load decode and commit
    wb_stage i_wb_stage (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready)
    );

    data_sram i_data_sram (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .rdata   (rdata),
        .busy    (busy)
    );

endmodule

/* hw/m1_stage.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module m1_stage import lsu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // from execute
    input  logic      es_valid,
    input  ex_to_m1_t es_bus,
    output logic      m1_allowin,
    // to mem_stage
    input  logic      ms_allowin,
    output logic      m1_to_ms_valid,
    output m1_to_ms_t m1_to_ms_bus,
    // to data memory
    output mem_req_t  mem_req
);

    logic       m1_valid;
    ex_to_m1_t  m1_bus_r;
    logic       is_store;
    logic       has_mem;
    logic [1:0] low;
    logic [3:0] wstrb;
    data_word_u st_data;

    // never stalls on its own
    assign m1_allowin     = !m1_valid || ms_allowin;
    assign m1_to_ms_valid = m1_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            m1_valid <= 1'b0;
        end else if (m1_allowin) begin
            m1_valid <= es_valid;
        end
    end

    // payload register qualified by m1_valid
    always_ff @(posedge clk) begin
        if (es_valid && m1_allowin) begin
            m1_bus_r <= es_bus;
        end
    end

    assign is_store = m1_bus_r.op[`MOP_SW] | m1_bus_r.op[`MOP_SB] | m1_bus_r.op[`MOP_SH];
    assign has_mem  = |m1_bus_r.op;
    assign low      = m1_bus_r.result[1:0];

    // byte strobes from op and low address bits
    always_comb begin
        wstrb = 4'b0000;
        if (m1_bus_r.op[`MOP_SW]) begin
            wstrb = 4'b1111;
        end else if (m1_bus_r.op[`MOP_SH]) begin
            wstrb = low[1] ? 4'b1100 : 4'b0011;
        end else if (m1_bus_r.op[`MOP_SB]) begin
            wstrb = 4'b0001 << low;
        end
    end

    // store data copied across every lane so the strobes pick the live one
    always_comb begin
        st_data.word = m1_bus_r.rt_value;
        if (m1_bus_r.op[`MOP_SB]) begin
            for (int i = 0; i < 4; i++) begin
                st_data.bytes[i] = m1_bus_r.rt_value[7:0];
            end
        end else if (m1_bus_r.op[`MOP_SH]) begin
            st_data.halves[0] = m1_bus_r.rt_value[15:0];
            st_data.halves[1] = m1_bus_r.rt_value[15:0];
        end
    end

    // request only on the handoff edge so each op reaches memory once
    assign mem_req.en    = m1_valid && ms_allowin && has_mem && !m1_bus_r.ex;
    assign mem_req.we    = is_store;
    assign mem_req.wstrb = wstrb;
    assign mem_req.addr  = m1_bus_r.result[`LSU_AW-1:0];
    assign mem_req.wdata = st_data.word;

    always_comb begin
        m1_to_ms_bus.op       = m1_bus_r.op;
        m1_to_ms_bus.ex       = m1_bus_r.ex;
        m1_to_ms_bus.gr_we    = m1_bus_r.gr_we;
        m1_to_ms_bus.dest     = m1_bus_r.dest;
        m1_to_ms_bus.result   = m1_bus_r.result;
        m1_to_ms_bus.rt_value = m1_bus_r.rt_value;
        m1_to_ms_bus.pc       = m1_bus_r.pc;
        // excepted ops never touch memory either
        m1_to_ms_bus.store_flow = is_store || !has_mem || m1_bus_r.ex;
    end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module mem_stage import lsu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // from m1_stage
    input  logic        m1_to_ms_valid,
    input  m1_to_ms_t   m1_to_ms_bus,
    output logic        ms_allowin,
    // to wb_stage
    input  logic        ws_allowin,
    output logic        ms_to_ws_valid,
    output ms_to_ws_t   ms_to_ws_bus,
    // from data memory
    input  logic [31:0] rdata,
    input  logic        busy,
    // bypass to decode
    output ms_fwd_t     ms_fwd
);

    logic      ms_valid;
    logic      ms_ready_go;
    logic      is_load;
    m1_to_ms_t ms_bus_r;

    // stores and non-memory ops skip the busy wait
    assign ms_ready_go    = ms_bus_r.store_flow || !busy;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= m1_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (m1_to_ms_valid && ms_allowin) begin
            ms_bus_r <= m1_to_ms_bus;
        end
    end

    assign is_load = ms_bus_r.op[`MOP_LW]  | ms_bus_r.op[`MOP_LB]  | ms_bus_r.op[`MOP_LBU] |
                     ms_bus_r.op[`MOP_LH]  | ms_bus_r.op[`MOP_LHU] | ms_bus_r.op[`MOP_LWL] |
                     ms_bus_r.op[`MOP_LWR];

    // memory holds rdata until the next read, so no capture here
    always_comb begin
        ms_to_ws_bus.op       = ms_bus_r.op;
        ms_to_ws_bus.ex       = ms_bus_r.ex;
        ms_to_ws_bus.gr_we    = ms_bus_r.gr_we;
        ms_to_ws_bus.dest     = ms_bus_r.dest;
        ms_to_ws_bus.result   = ms_bus_r.result;
        ms_to_ws_bus.rt_value = ms_bus_r.rt_value;
        ms_to_ws_bus.pc       = ms_bus_r.pc;
        ms_to_ws_bus.rdata    = rdata;
    end

    // dest only while the output is valid
    assign ms_fwd.dest   = ms_bus_r.dest & {5{ms_to_ws_valid}};
    assign ms_fwd.result = ms_bus_r.result;
    // load result not final until wb, decode must stall on it
    assign ms_fwd.load_op = ms_valid && is_load;

endmodule

/* hw/wb_stage.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module wb_stage import lsu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // from mem_stage
    input  logic       ms_to_ws_valid,
    input  ms_to_ws_t  ms_to_ws_bus,
    output logic       ws_allowin,
    // register-file commit
    output logic       commit_valid,
    output wb_commit_t commit,
    input  logic       commit_ready
);

    logic        ws_valid;
    ms_to_ws_t   ws_bus_r;
    data_word_u  rd;
    logic [1:0]  low;
    logic [31:0] rt;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] final_data;

    // only commit_ready holds this stage
    assign ws_allowin   = !ws_valid || commit_ready;
    assign commit_valid = ws_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus_r <= ms_to_ws_bus;
        end
    end

    assign rd.word  = ws_bus_r.rdata;
    assign low      = ws_bus_r.result[1:0];
    assign rt       = ws_bus_r.rt_value;
    // lane pick by low address bits
    assign sel_byte = rd.bytes[low];
    assign sel_half = rd.halves[low[1]];

    always_comb begin
        final_data = ws_bus_r.result;
        if (!ws_bus_r.ex) begin
            if (ws_bus_r.op[`MOP_LW]) begin
                final_data = rd.word;
            end else if (ws_bus_r.op[`MOP_LB]) begin
                final_data = {{24{sel_byte[7]}}, sel_byte};
            end else if (ws_bus_r.op[`MOP_LBU]) begin
                final_data = {24'd0, sel_byte};
            end else if (ws_bus_r.op[`MOP_LH]) begin
                final_data = {{16{sel_half[15]}}, sel_half};
            end else if (ws_bus_r.op[`MOP_LHU]) begin
                final_data = {16'd0, sel_half};
            end else if (ws_bus_r.op[`MOP_LWL]) begin
                // low memory bytes fill the top of rt
                case (low)
                    2'd0:    final_data = {rd.bytes[0], rt[23:0]};
                    2'd1:    final_data = {rd.halves[0], rt[15:0]};
                    2'd2:    final_data = {rd.word[23:0], rt[7:0]};
                    default: final_data = rd.word;
                endcase
            end else if (ws_bus_r.op[`MOP_LWR]) begin
                // mirror image where high memory bytes fill the bottom
                case (low)
                    2'd0:    final_data = rd.word;
                    2'd1:    final_data = {rt[31:24], rd.word[31:8]};
                    2'd2:    final_data = {rt[31:16], rd.halves[1]};
                    default: final_data = {rt[31:8], rd.bytes[3]};
                endcase
            end
        end
    end

    // excepted op is still reported but writes nothing
    assign commit.gr_we = ws_bus_r.gr_we && !ws_bus_r.ex;
    assign commit.dest  = ws_bus_r.dest;
    assign commit.data  = final_data;
    assign commit.ex    = ws_bus_r.ex;
    assign commit.pc    = ws_bus_r.pc;

endmodule

/* src.f */
+incdir+hw
hw/lsu_pkg.sv
hw/data_sram.sv
hw/m1_stage.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/lsu_top.sv
bench/lsu_tb.sv
